//--- Makefile
TB = issueStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module issueStage -f list.f

sim:
	verilator --binary --timing --top-module $(TB) -Mdir obj_dir -f list.f
	./obj_dir/V$(TB) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
+incdir+verilog
verilog/renamePkg.sv
verilog/regFile.sv
verilog/reorderBuffer.sv
verilog/operandResolve.sv
verilog/issueStage.sv
test/issueChecker.sv
test/issueStageTb.sv

//--- test/issueChecker.sv
`timescale 1ns/1ns
`include "rename_params.svh"

module issueChecker (
    input  logic                clk, rst, rdy, clr, issueEn, pd, wbEn,
    input  renamePkg::regName_t rs1Name, rs2Name, rdName,
    input  renamePkg::op_t      op,
    input  renamePkg::addr_t    pc,
    input  renamePkg::imm_t     imm,
    input  renamePkg::nick_t    wbNick,
    input  renamePkg::data_t    wbData,
    input  logic                robFull, commitEn, dpEn, dpPd,
    input  renamePkg::regName_t commitName, dpRdName,
    input  renamePkg::nick_t    commitNick, dpRs1Nick, dpRs2Nick, dpNick,
    input  renamePkg::data_t    commitData, dpRs1Data, dpRs2Data,
    input  renamePkg::op_t      dpOp,
    input  renamePkg::addr_t    dpPc,
    input  renamePkg::imm_t     dpImm,
    output int                  errorCount, checkCount, commitCount, fullCount, outstanding
);

    renamePkg::data_t    regVal   [`REG_NUM];
    renamePkg::nick_t    regNick  [`REG_NUM];
    renamePkg::regName_t robName  [`ROB_DEPTH];
    renamePkg::data_t    robVal   [`ROB_DEPTH];
    logic                robReady [`ROB_DEPTH];
    int                  head;
    int                  tail;

    logic                expValid;
    renamePkg::data_t    expData1, expData2;
    renamePkg::nick_t    expNick1, expNick2, expNick;
    logic [`REG_NAME_W+`OP_W+`ADDR_W+`IMM_W:0] expPass;   // Name, op, pc, imm, pd.

    // Expected source operand. The first matching case wins.
    function automatic void expectOperand(input renamePkg::regName_t name,
                                          output renamePkg::data_t data,
                                          output renamePkg::nick_t nick);
        renamePkg::nick_t tag;
        tag  = regNick[name];
        data = '0;
        nick = '0;
        if (name == '0) begin
            data = '0;
        end else if (tag == '0) begin
            data = regVal[name];
        end else if (wbEn && (wbNick == tag)) begin
            data = wbData;                                  // Result arriving now.
        end else if (robReady[int'(tag) - 1]) begin
            data = robVal[int'(tag) - 1];
        end else begin
            nick = tag;
        end
    endfunction

    task automatic checkField(input logic ok, input string what);
        checkCount++;
        if (!ok) begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s", $time, what);
        end
    endtask

    // Inputs and outputs are settled at the falling edge.
    always @(negedge clk) begin : edgeModel
        logic accept;
        logic commitNow;
        int   slot;
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regVal[i]  = '0;
                regNick[i] = '0;
            end
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                robReady[i] = 1'b0;
            end
            head        = 0;
            tail        = 0;
            outstanding = 0;
            expValid    = 1'b0;
            errorCount  = 0;
            checkCount  = 0;
            commitCount = 0;
            fullCount   = 0;
        end else begin
            checkField(dpEn === expValid, $sformatf("dpEn %b, expected %b", dpEn, expValid));
            if (expValid) begin
                checkField(dpRs1Data === expData1,
                           $sformatf("dpRs1Data %h, expected %h", dpRs1Data, expData1));
                checkField(dpRs1Nick === expNick1,
                           $sformatf("dpRs1Nick %0d, expected %0d", dpRs1Nick, expNick1));
                checkField(dpRs2Data === expData2,
                           $sformatf("dpRs2Data %h, expected %h", dpRs2Data, expData2));
                checkField(dpRs2Nick === expNick2,
                           $sformatf("dpRs2Nick %0d, expected %0d", dpRs2Nick, expNick2));
                checkField(dpNick === expNick,
                           $sformatf("dpNick %0d, expected %0d", dpNick, expNick));
                checkField({dpRdName, dpOp, dpPc, dpImm, dpPd} === expPass,
                           $sformatf("dispatch fields %h, expected %h",
                                     {dpRdName, dpOp, dpPc, dpImm, dpPd}, expPass));
            end
            checkField(robFull === (outstanding == `ROB_DEPTH),
                       $sformatf("robFull %b with %0d entries", robFull, outstanding));
            commitNow = rdy && !clr && (outstanding != 0) && robReady[head];
            checkField(commitEn === commitNow,
                       $sformatf("commitEn %b, expected %b", commitEn, commitNow));
            if (commitNow) begin
                checkField({commitName, commitNick, commitData} ===
                           {robName[head], renamePkg::nick_t'(head + 1), robVal[head]},
                           $sformatf("commit %0d/%0d/%h, expected %0d/%0d/%h",
                                     commitName, commitNick, commitData,
                                     robName[head], head + 1, robVal[head]));
            end
            if (outstanding == `ROB_DEPTH) begin
                fullCount++;
            end

            accept   = rdy && issueEn && !clr && (outstanding != `ROB_DEPTH);
            expValid = accept;
            if (accept) begin
                expectOperand(rs1Name, expData1, expNick1);       // Before the rename.
                expectOperand(rs2Name, expData2, expNick2);
                expNick = renamePkg::nick_t'(tail + 1);
                expPass = {rdName, op, pc, imm, pd};
            end

            if (rdy && clr) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regNick[i] = '0;
                end
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    robReady[i] = 1'b0;
                end
                head        = 0;
                tail        = 0;
                outstanding = 0;
            end else if (rdy) begin
                if (commitNow) begin
                    if (robName[head] != '0) begin
                        regVal[robName[head]] = robVal[head];
                        if (regNick[robName[head]] == renamePkg::nick_t'(head + 1)) begin
                            regNick[robName[head]] = '0;
                        end
                    end
                    head = (head + 1) % `ROB_DEPTH;
                    outstanding--;
                    commitCount++;
                end
                if (wbEn && (wbNick != '0)) begin
                    slot           = int'(wbNick) - 1;
                    robReady[slot] = 1'b1;
                    robVal[slot]   = wbData;
                end
                if (accept) begin
                    robName[tail]  = rdName;
                    robReady[tail] = 1'b0;
                    if (rdName != '0) begin
                        regNick[rdName] = renamePkg::nick_t'(tail + 1);   // Wins over a clear.
                    end
                    tail = (tail + 1) % `ROB_DEPTH;
                    outstanding++;
                end
            end
        end
    end

endmodule

//--- test/issueStageTb.sv
`timescale 1ns/1ns

module issueStageTb;

    logic                clk;
    logic                rst, rdy, clr, issueEn, pd, wbEn;
    renamePkg::regName_t rs1Name, rs2Name, rdName;
    renamePkg::op_t      op;
    renamePkg::addr_t    pc;
    renamePkg::imm_t     imm;
    renamePkg::nick_t    wbNick;
    renamePkg::data_t    wbData;

    logic                robFull, commitEn, dpEn, dpPd;
    renamePkg::regName_t commitName, dpRdName;
    renamePkg::nick_t    commitNick, dpRs1Nick, dpRs2Nick, dpNick;
    renamePkg::data_t    commitData, dpRs1Data, dpRs2Data;
    renamePkg::op_t      dpOp;
    renamePkg::addr_t    dpPc;
    renamePkg::imm_t     dpImm;

    int                  errorCount, checkCount, commitCount, fullCount, outstanding;
    int                  otherErrors;
    int                  seed;
    renamePkg::nick_t    openNicks [$];                   // Allocated and not yet written back.

    issueStage issueStage_i (.*);

    issueChecker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Mostly a few names for many hazards. Any register now and then.
    function automatic renamePkg::regName_t pickName();
        int range;
        range = (pick(4) == 0) ? (1 << $bits(renamePkg::regName_t)) : 8;
        return renamePkg::regName_t'(pick(range));
    endfunction

    // One cycle of random issue, writeback, stall and flush.
    task automatic randomCycle();
        int idx;
        rdy     = (pick(10) != 0);
        clr     = rdy && (pick(120) == 0);
        issueEn = !robFull && (pick(4) != 0);
        rs1Name = pickName();
        rs2Name = pickName();
        rdName  = pickName();
        op      = renamePkg::op_t'(pick(64));
        pc      = $random(seed);
        imm     = $random(seed);
        pd      = (pick(2) == 1);
        wbEn    = 1'b0;
        if ((openNicks.size() != 0) && (pick(3) == 0)) begin
            idx    = pick(openNicks.size());
            wbEn   = 1'b1;
            wbNick = openNicks[idx];
            wbData = $random(seed);
            if (rdy && !clr) begin
                openNicks.delete(idx);
            end
        end
        if (rdy && clr) begin
            openNicks.delete();
        end
    endtask

    initial begin
        int cycle;
        seed        = 32'h7a9e_a01e;
        otherErrors = 0;
        rst         = 1'b1;
        rdy         = 1'b0;
        clr         = 1'b0;
        issueEn     = 1'b0;
        rs1Name     = '0;
        rs2Name     = '0;
        rdName      = '0;
        op          = '0;
        pc          = '0;
        imm         = '0;
        pd          = 1'b0;
        wbEn        = 1'b0;
        wbNick      = '0;
        wbData      = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        rdy = 1'b1;
        for (int c = 0; c < 4000; c++) begin
            @(posedge clk);
            #1;
            if (dpEn) begin
                openNicks.push_back(dpNick);
            end
            randomCycle();
        end
        // Stop issuing and write back everything still open.
        cycle = 0;
        do begin
            @(posedge clk);
            #1;
            if (dpEn) begin
                openNicks.push_back(dpNick);
            end
            rdy     = 1'b1;
            clr     = 1'b0;
            issueEn = 1'b0;
            wbEn    = 1'b0;
            if (openNicks.size() != 0) begin
                wbEn   = 1'b1;
                wbNick = openNicks.pop_front();
                wbData = $random(seed);
            end
            cycle++;
        end while (((outstanding != 0) || (openNicks.size() != 0)) && (cycle < 200));
        if ((outstanding != 0) || (openNicks.size() != 0)) begin
            $display("Timeout: the reorder buffer did not drain, %0d entries left", outstanding);
            otherErrors++;
        end
        repeat (2) @(posedge clk);
        if ((commitCount == 0) || (fullCount == 0)) begin
            $display("Stimulus never filled the buffer or never saw a commit");
            otherErrors++;
        end
        $display("Checks %0d, mismatches %0d, other errors %0d, commits %0d, full cycles %0d",
                 checkCount, errorCount, otherErrors, commitCount, fullCount);
        if ((errorCount == 0) && (otherErrors == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/issueStage.sv
`timescale 1ns/1ns

module issueStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                clr,

    // Issue from decode.
    input  logic                issueEn,
    input  renamePkg::regName_t rs1Name,
    input  renamePkg::regName_t rs2Name,
    input  renamePkg::regName_t rdName,
    input  renamePkg::op_t      op,
    input  renamePkg::addr_t    pc,
    input  renamePkg::imm_t     imm,
    input  logic                pd,
    output logic                robFull,

    // Writeback from execution.
    input  logic                wbEn,
    input  renamePkg::nick_t    wbNick,
    input  renamePkg::data_t    wbData,

    // Commit.
    output logic                commitEn,
    output renamePkg::regName_t commitName,
    output renamePkg::nick_t    commitNick,
    output renamePkg::data_t    commitData,

    // Dispatch.
    output logic                dpEn,
    output renamePkg::data_t    dpRs1Data,
    output renamePkg::nick_t    dpRs1Nick,
    output renamePkg::data_t    dpRs2Data,
    output renamePkg::nick_t    dpRs2Nick,
    output renamePkg::regName_t dpRdName,
    output renamePkg::nick_t    dpNick,
    output renamePkg::op_t      dpOp,
    output renamePkg::addr_t    dpPc,
    output renamePkg::imm_t     dpImm,
    output logic                dpPd
);

    logic             issueAccept;
    renamePkg::nick_t allocNick;
    renamePkg::data_t rs1Data;
    renamePkg::data_t rs2Data;
    renamePkg::nick_t rs1Nick;
    renamePkg::nick_t rs2Nick;
    renamePkg::nick_t lookNick1;
    renamePkg::nick_t lookNick2;
    logic             lookReady1;
    logic             lookReady2;
    renamePkg::data_t lookData1;
    renamePkg::data_t lookData2;

    assign issueAccept = issueEn && rdy && !robFull;  // Issue while full is dropped.

    regFile regFile_i (
        .clk, .rst, .rdy, .clr,
        .issueAccept, .rs1Name, .rs2Name, .rdName, .allocNick,
        .commitEn, .commitName, .commitNick, .commitData,
        .rs1Data, .rs2Data, .rs1Nick, .rs2Nick
    );

    reorderBuffer reorderBuffer_i (
        .clk, .rst, .rdy, .clr,
        .issueAccept, .rdName, .robFull, .allocNick,
        .wbEn, .wbNick, .wbData,
        .lookNick1, .lookNick2, .lookReady1, .lookReady2, .lookData1, .lookData2,
        .commitEn, .commitName, .commitNick, .commitData
    );

    operandResolve operandResolve_i (
        .clk, .rst, .rdy, .clr,
        .issueAccept, .rs1Name, .rs2Name, .rdName, .op, .pc, .imm, .pd, .allocNick,
        .rs1Data, .rs2Data, .rs1Nick, .rs2Nick,
        .lookNick1, .lookNick2, .lookReady1, .lookReady2, .lookData1, .lookData2,
        .wbEn, .wbNick, .wbData,
        .dpEn, .dpRs1Data, .dpRs1Nick, .dpRs2Data, .dpRs2Nick,
        .dpRdName, .dpNick, .dpOp, .dpPc, .dpImm, .dpPd
    );

endmodule

//--- verilog/operandResolve.sv
`timescale 1ns/1ns

module operandResolve (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                clr,

    // Instruction being issued.
    input  logic                issueAccept,
    input  renamePkg::regName_t rs1Name,
    input  renamePkg::regName_t rs2Name,
    input  renamePkg::regName_t rdName,
    input  renamePkg::op_t      op,
    input  renamePkg::addr_t    pc,
    input  renamePkg::imm_t     imm,
    input  logic                pd,
    input  renamePkg::nick_t    allocNick,

    // Register file reads.
    input  renamePkg::data_t    rs1Data,
    input  renamePkg::data_t    rs2Data,
    input  renamePkg::nick_t    rs1Nick,
    input  renamePkg::nick_t    rs2Nick,

    // Reorder buffer lookup.
    output renamePkg::nick_t    lookNick1,
    output renamePkg::nick_t    lookNick2,
    input  logic                lookReady1,
    input  logic                lookReady2,
    input  renamePkg::data_t    lookData1,
    input  renamePkg::data_t    lookData2,

    // Writeback bypass.
    input  logic                wbEn,
    input  renamePkg::nick_t    wbNick,
    input  renamePkg::data_t    wbData,

    // Dispatch.
    output logic                dpEn,
    output renamePkg::data_t    dpRs1Data,
    output renamePkg::nick_t    dpRs1Nick,
    output renamePkg::data_t    dpRs2Data,
    output renamePkg::nick_t    dpRs2Nick,
    output renamePkg::regName_t dpRdName,
    output renamePkg::nick_t    dpNick,
    output renamePkg::op_t      dpOp,
    output renamePkg::addr_t    dpPc,
    output renamePkg::imm_t     dpImm,
    output logic                dpPd
);

    renamePkg::data_t srcData1;
    renamePkg::data_t srcData2;
    renamePkg::nick_t srcNick1;
    renamePkg::nick_t srcNick2;
    logic             capture;

    function automatic void resolve(
        input  renamePkg::regName_t name,
        input  renamePkg::data_t    regData,
        input  renamePkg::nick_t    regNick,
        input  logic                bufReady,
        input  renamePkg::data_t    bufData,
        input  logic                bypassEn,
        input  renamePkg::nick_t    bypassNick,
        input  renamePkg::data_t    bypassData,
        output renamePkg::data_t    data,
        output renamePkg::nick_t    nick
    );
        data = '0;
        nick = '0;
        if (name == '0) begin
            data = '0;
        end else if (regNick == '0) begin
            data = regData;                           // Committed value.
        end else if (bypassEn && (bypassNick == regNick)) begin
            data = bypassData;                        // Result arriving now.
        end else if (bufReady) begin
            data = bufData;
        end else begin
            nick = regNick;                           // Still pending.
        end
    endfunction

    assign lookNick1 = rs1Nick;
    assign lookNick2 = rs2Nick;

    always_comb begin
        resolve(rs1Name, rs1Data, rs1Nick, lookReady1, lookData1,
                wbEn, wbNick, wbData, srcData1, srcNick1);
        resolve(rs2Name, rs2Data, rs2Nick, lookReady2, lookData2,
                wbEn, wbNick, wbData, srcData2, srcNick2);
    end

    assign capture = issueAccept && rdy && !clr;

    always_ff @(posedge clk) begin
        if (rst) begin
            dpEn <= 1'b0;
        end else begin
            dpEn <= capture;                          // One cycle per accepted issue.
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dpRs1Data <= srcData1;
            dpRs1Nick <= srcNick1;
            dpRs2Data <= srcData2;
            dpRs2Nick <= srcNick2;
            dpRdName  <= rdName;
            dpNick    <= allocNick;
            dpOp      <= op;
            dpPc      <= pc;
            dpImm     <= imm;
            dpPd      <= pd;
        end
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ns
`include "rename_params.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                clr,

    // Issue side.
    input  logic                issueAccept,
    input  renamePkg::regName_t rs1Name,
    input  renamePkg::regName_t rs2Name,
    input  renamePkg::regName_t rdName,
    input  renamePkg::nick_t    allocNick,

    // Commit from the reorder buffer.
    input  logic                commitEn,
    input  renamePkg::regName_t commitName,
    input  renamePkg::nick_t    commitNick,
    input  renamePkg::data_t    commitData,

    // Source read ports.
    output renamePkg::data_t    rs1Data,
    output renamePkg::data_t    rs2Data,
    output renamePkg::nick_t    rs1Nick,
    output renamePkg::nick_t    rs2Nick
);

    renamePkg::data_t values [`REG_NUM];
    renamePkg::nick_t nicks  [`REG_NUM];

    logic commitWrite;
    logic renameWrite;
    logic commitClear;

    // Reads see the state before this cycle's rename.
    assign rs1Data = values[rs1Name];
    assign rs2Data = values[rs2Name];
    assign rs1Nick = nicks[rs1Name];
    assign rs2Nick = nicks[rs2Name];

    assign commitWrite = commitEn && (commitName != '0);      // x0 stays zero.
    assign renameWrite = issueAccept && (rdName != '0);

    // Only the latest writer may release the binding.
    assign commitClear = commitWrite && (nicks[commitName] == commitNick);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                values[i] <= '0;
                nicks[i]  <= '0;
            end
        end else if (rdy) begin
            if (clr) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    nicks[i] <= '0;                           // Values survive a flush.
                end
            end else begin
                if (commitWrite) begin
                    values[commitName] <= commitData;
                end
                if (commitClear) begin
                    nicks[commitName] <= '0;
                end
                // Later assignment wins, so a fresh rename beats the clear.
                if (renameWrite) begin
                    nicks[rdName] <= allocNick;
                end
            end
        end
    end

endmodule

//--- verilog/renamePkg.sv
`include "rename_params.svh"

package renamePkg;

    // Architectural register name.
    typedef logic [`REG_NAME_W-1:0] regName_t;

    // Reorder buffer tag. Zero when no writer is pending.
    typedef logic [`NICK_W-1:0] nick_t;

    // Register and result value.
    typedef logic [`DATA_W-1:0] data_t;

    // Operation code from decode.
    typedef logic [`OP_W-1:0] op_t;

    // Instruction address.
    typedef logic [`ADDR_W-1:0] addr_t;

    // Immediate operand.
    typedef logic [`IMM_W-1:0] imm_t;

endpackage

//--- verilog/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural register file.
`define REG_NUM    32
`define REG_NAME_W 5
`define DATA_W     32

// Reorder buffer. A nick is entry index plus one, zero means no writer.
`define ROB_DEPTH  8
`define NICK_W     4

// Instruction fields passed through to dispatch.
`define OP_W       6
`define ADDR_W     32
`define IMM_W      32

`endif

//--- verilog/reorderBuffer.sv
`timescale 1ns/1ns
`include "rename_params.svh"

module reorderBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                clr,

    // Allocation.
    input  logic                issueAccept,
    input  renamePkg::regName_t rdName,
    output logic                robFull,
    output renamePkg::nick_t    allocNick,

    // Writeback.
    input  logic                wbEn,
    input  renamePkg::nick_t    wbNick,
    input  renamePkg::data_t    wbData,

    // Operand lookup.
    input  renamePkg::nick_t    lookNick1,
    input  renamePkg::nick_t    lookNick2,
    output logic                lookReady1,
    output logic                lookReady2,
    output renamePkg::data_t    lookData1,
    output renamePkg::data_t    lookData2,

    // In-order commit.
    output logic                commitEn,
    output renamePkg::regName_t commitName,
    output renamePkg::nick_t    commitNick,
    output renamePkg::data_t    commitData
);

    localparam int IDX_W = $clog2(`ROB_DEPTH);

    renamePkg::regName_t names  [`ROB_DEPTH];
    renamePkg::data_t    values [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] readyFlags;

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;

    logic [IDX_W-1:0] wbIdx;
    logic [IDX_W-1:0] lookIdx1;
    logic [IDX_W-1:0] lookIdx2;
    logic             wbWrite;

    function automatic logic [IDX_W-1:0] nextPtr(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign robFull   = (count == (IDX_W + 1)'(`ROB_DEPTH));
    assign allocNick = renamePkg::nick_t'(tail) + 1'b1;

    // Nick to entry index.
    assign wbIdx    = IDX_W'(wbNick - 1'b1);
    assign lookIdx1 = IDX_W'(lookNick1 - 1'b1);
    assign lookIdx2 = IDX_W'(lookNick2 - 1'b1);
    assign wbWrite  = wbEn && (wbNick != '0);

    assign lookReady1 = (lookNick1 != '0) && readyFlags[lookIdx1];
    assign lookReady2 = (lookNick2 != '0) && readyFlags[lookIdx2];
    assign lookData1  = values[lookIdx1];
    assign lookData2  = values[lookIdx2];

    // Head retires at the edge while commitEn is high.
    assign commitEn   = rdy && !clr && (count != '0) && readyFlags[head];
    assign commitName = names[head];
    assign commitNick = renamePkg::nick_t'(head) + 1'b1;
    assign commitData = values[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            readyFlags <= '0;
        end else if (rdy) begin
            if (clr) begin
                head       <= '0;
                tail       <= '0;
                count      <= '0;
                readyFlags <= '0;
            end else begin
                if (issueAccept) begin
                    readyFlags[tail] <= 1'b0;
                    tail             <= nextPtr(tail);
                end
                if (wbWrite) begin
                    readyFlags[wbIdx] <= 1'b1;
                end
                if (commitEn) begin
                    head <= nextPtr(head);
                end
                case ({issueAccept, commitEn})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;          // Both or neither.
                endcase
            end
        end
    end

    // Entry payload is kept after retirement until reallocated.
    always_ff @(posedge clk) begin
        if (rdy && !clr) begin
            if (issueAccept) begin
                names[tail] <= rdName;
            end
            if (wbWrite) begin
                values[wbIdx] <= wbData;
            end
        end
    end

endmodule
